// ==== hdl/gbe_cpu_pkg.sv ====
`default_nettype none

package gbe_cpu_pkg;

  // address windows, 14-bit byte addresses
  localparam logic [13:0] REGS_BASE  = 14'h0000;
  localparam logic [13:0] REGS_HIGH  = 14'h07FF;
  localparam logic [13:0] TXBUF_BASE = 14'h1000;
  localparam logic [13:0] TXBUF_HIGH = 14'h17FF;
  localparam logic [13:0] RXBUF_BASE = 14'h2000;
  localparam logic [13:0] RXBUF_HIGH = 14'h27FF;
  localparam logic [13:0] ARP_BASE   = 14'h3000;
  localparam logic [13:0] ARP_HIGH   = 14'h37FF;

  // register word indices
  localparam logic [3:0] REG_MAC_HI      = 4'd0;
  localparam logic [3:0] REG_MAC_LO      = 4'd1;
  localparam logic [3:0] REG_GATEWAY     = 4'd3;
  localparam logic [3:0] REG_IPADDR      = 4'd4;
  localparam logic [3:0] REG_BUF_SIZES   = 4'd6;
  localparam logic [3:0] REG_PORTS       = 4'd8;
  localparam logic [3:0] REG_CAPS        = 4'd9;
  localparam logic [3:0] REG_PHY_STATUS  = 4'd10;
  localparam logic [3:0] REG_PHY_CONTROL = 4'd11;

  localparam logic [47:0] RST_MAC         = 48'hffff_ffff_ffff;
  localparam logic [31:0] RST_IP          = 32'hffff_ffff;
  localparam logic [15:0] RST_PORT        = 16'hffff;
  localparam logic [7:0]  RST_GATEWAY     = 8'd0;
  localparam logic        RST_ENABLE      = 1'b0;
  localparam logic        RST_PROMISC     = 1'b0;
  localparam logic [31:0] RST_PHY_CONTROL = 32'd0;

  localparam logic CAP_TX = 1'b1;
  localparam logic CAP_RX = 1'b1;

  localparam int ARP_DEPTH   = 256;
  localparam int ARP_WIDTH   = 48;
  localparam int TXBUF_DEPTH = 512;
  localparam int TXBUF_WIDTH = 32;

  // offset inside a 2 KB window
  typedef union packed {
    struct packed {
      logic [4:0] unused;
      logic [3:0] idx;
      logic [1:0] byte_off;
    } reg_view;
    struct packed {
      logic [8:0] word;
      logic [1:0] byte_off;
    } buf_view;
    struct packed {
      logic [7:0] entry;
      logic       half;  // 1 selects entry bits 31:0
      logic [1:0] byte_off;
    } arp_view;
  } gbe_cpu_offset_u;

  typedef struct packed {
    logic regs;
    logic txbuf;
    logic rxbuf;
    logic arp;
  } gbe_cpu_region_t;

  typedef struct packed {
    logic            trans;
    logic            we;
    logic [3:0]      sel;
    gbe_cpu_region_t region;
    gbe_cpu_offset_u offset;
    logic [31:0]     din;
  } gbe_cpu_req_t;

  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] ip;
    logic [7:0]  gateway;
    logic [15:0] port;
    logic        enable;
    logic        promisc;
    logic [31:0] phy_control;
  } gbe_cpu_cfg_t;

  // replace the selected byte lanes of old_word
  function automatic logic [31:0] lane_merge(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  sel);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        res[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== hdl/gbe_cpu_dp_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module gbe_cpu_dp_ram #(
  parameter int DEPTH = 256,
  parameter int WIDTH = 32
) (
  input  wire                      cpu_clk,
  input  wire [$clog2(DEPTH)-1:0]  a_addr_i,
  input  wire                      a_we_i,
  input  wire [WIDTH-1:0]          a_wdata_i,
  input  wire [$clog2(DEPTH)-1:0]  b_addr_i,
  output logic [WIDTH-1:0]         a_rdata_o,
  output logic [WIDTH-1:0]         b_rdata_o
);

  logic [WIDTH-1:0] mem [DEPTH];

  // port a returns the old word on a write
  always_ff @(posedge cpu_clk) begin
    if (a_we_i) begin
      mem[a_addr_i] <= a_wdata_i;
    end
    a_rdata_o <= mem[a_addr_i];
  end

  // packet side
  always_ff @(posedge cpu_clk) begin
    b_rdata_o <= mem[b_addr_i];
  end

endmodule

`default_nettype wire

// ==== hdl/gbe_cpu_bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module gbe_cpu_bus_decode (
  input  wire                       cpu_clk,
  input  wire                       cpu_rst,
  input  wire                       wb_cyc_i,
  input  wire                       wb_stb_i,
  input  wire                       wb_we_i,
  input  wire [13:0]                wb_adr_i,
  input  wire [3:0]                 wb_sel_i,
  input  wire [31:0]                wb_dat_i,
  output gbe_cpu_pkg::gbe_cpu_req_t req_o,
  output logic                      wait_phase_o,
  output logic                      wb_ack_o
);

  import gbe_cpu_pkg::*;

  gbe_cpu_region_t region;
  logic            trans;
  logic            mem_write;

  always_comb begin
    region.regs  = (wb_adr_i >= REGS_BASE) && (wb_adr_i <= REGS_HIGH);
    region.txbuf = (wb_adr_i >= TXBUF_BASE) && (wb_adr_i <= TXBUF_HIGH);
    region.rxbuf = (wb_adr_i >= RXBUF_BASE) && (wb_adr_i <= RXBUF_HIGH);
    region.arp   = (wb_adr_i >= ARP_BASE) && (wb_adr_i <= ARP_HIGH);
  end

  // no new transaction while ack or the wait state is pending
  assign trans     = wb_cyc_i && wb_stb_i && !wb_ack_o && !wait_phase_o;
  assign mem_write = wb_we_i && (region.arp || region.txbuf);

  always_comb begin
    req_o.trans  = trans;
    req_o.we     = wb_we_i;
    req_o.sel    = wb_sel_i;
    req_o.region = region;
    req_o.offset = wb_adr_i[10:0];
    req_o.din    = wb_dat_i;
  end

  // memory writes take one extra cycle for the read-modify-write
  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      wait_phase_o <= 1'b0;
      wb_ack_o     <= 1'b0;
    end else begin
      wait_phase_o <= trans && mem_write;
      wb_ack_o     <= (trans && !mem_write) || wait_phase_o;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/gbe_cpu_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module gbe_cpu_regs (
  input  wire                       cpu_clk,
  input  wire                       cpu_rst,
  input  gbe_cpu_pkg::gbe_cpu_req_t req_i,
  input  wire                       rx_ready_i,
  input  wire [11:0]                rx_size_i,
  input  wire                       tx_done_i,
  output gbe_cpu_pkg::gbe_cpu_cfg_t cfg_o,
  output logic [11:0]               tx_size_o,
  output logic                      tx_ready_o,
  output logic                      rx_ack_o,
  output logic [12:0]               rx_size_o
);

  import gbe_cpu_pkg::*;

  gbe_cpu_cfg_t cfg_q;
  logic         reg_write;
  logic [3:0]   idx;
  logic [3:0]   sel;
  logic [31:0]  din;

  assign reg_write = req_i.trans && req_i.we && req_i.region.regs;
  assign idx       = req_i.offset.reg_view.idx;
  assign sel       = req_i.sel;
  assign din       = req_i.din;
  assign cfg_o     = cfg_q;

  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      cfg_q.mac         <= RST_MAC;
      cfg_q.ip          <= RST_IP;
      cfg_q.gateway     <= RST_GATEWAY;
      cfg_q.port        <= RST_PORT;
      cfg_q.enable      <= RST_ENABLE;
      cfg_q.promisc     <= RST_PROMISC;
      cfg_q.phy_control <= RST_PHY_CONTROL;
    end else if (reg_write) begin
      case (idx)
        REG_MAC_HI: begin
          if (sel[0]) begin
            cfg_q.mac[39:32] <= din[7:0];
          end
          if (sel[1]) begin
            cfg_q.mac[47:40] <= din[15:8];
          end
        end
        REG_MAC_LO: begin
          cfg_q.mac[31:0] <= lane_merge(cfg_q.mac[31:0], din, sel);
        end
        REG_GATEWAY: begin
          if (sel[0]) begin
            cfg_q.gateway <= din[7:0];
          end
        end
        REG_IPADDR: begin
          cfg_q.ip <= lane_merge(cfg_q.ip, din, sel);
        end
        REG_PORTS: begin
          if (sel[0]) begin
            cfg_q.port[7:0] <= din[7:0];
          end
          if (sel[1]) begin
            cfg_q.port[15:8] <= din[15:8];
          end
          if (sel[2]) begin
            cfg_q.enable <= din[16];
          end
          if (sel[3]) begin
            cfg_q.promisc <= din[24];
          end
        end
        REG_PHY_CONTROL: begin
          cfg_q.phy_control <= lane_merge(cfg_q.phy_control, din, sel);
        end
        default: begin
        end
      endcase
    end
  end

  // buffer handshakes, later assignments win
  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      tx_size_o  <= 12'd0;
      tx_ready_o <= 1'b0;
      rx_size_o  <= 13'd0;
      rx_ack_o   <= 1'b0;
    end else begin
      // packet sent, hand the buffer back
      if (tx_done_i) begin
        tx_size_o  <= 12'd0;
        tx_ready_o <= 1'b0;
      end

      // buffer empty, ask the engine for the next packet
      if (rx_size_o == 13'd0 && rx_ready_i) begin
        rx_ack_o <= 1'b1;
      end
      if (rx_ready_i && rx_ack_o) begin
        rx_size_o <= {1'b0, rx_size_i} + 13'd1;
        rx_ack_o  <= 1'b0;
      end

      if (reg_write && idx == REG_BUF_SIZES) begin
        if (sel[0] && din[12:0] == 13'd0) begin
          rx_size_o <= 13'd0;
        end
        if (sel[2]) begin
          tx_size_o[7:0] <= din[23:16];
          tx_ready_o     <= 1'b1;
        end
        if (sel[3]) begin
          tx_size_o[11:8] <= din[27:24];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/gbe_cpu_mem_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module gbe_cpu_mem_merge (
  input  wire                       cpu_clk,
  input  wire                       cpu_rst,
  input  gbe_cpu_pkg::gbe_cpu_req_t req_i,
  input  wire                       wait_phase_i,
  input  wire [47:0]                arp_rd_data_i,
  input  wire [31:0]                tx_rd_data_i,
  output logic [47:0]               wr_data_o,
  output logic                      arp_we_o,
  output logic                      tx_we_o
);

  import gbe_cpu_pkg::*;

  logic [31:0] arp_lo_merged;
  logic [31:0] arp_hi_merged;
  logic [31:0] tx_merged;

  // high half of an entry only has lanes 0 and 1
  always_comb begin
    arp_lo_merged = lane_merge(arp_rd_data_i[31:0], req_i.din, req_i.sel);
    arp_hi_merged = lane_merge({16'h0, arp_rd_data_i[47:32]}, req_i.din,
                               {2'b00, req_i.sel[1:0]});
    tx_merged     = lane_merge(tx_rd_data_i, req_i.din, req_i.sel);
  end

  always_ff @(posedge cpu_clk) begin
    if (wait_phase_i) begin
      if (req_i.region.arp) begin
        if (req_i.offset.arp_view.half) begin
          wr_data_o <= {arp_rd_data_i[47:32], arp_lo_merged};
        end else begin
          wr_data_o <= {arp_hi_merged[15:0], arp_rd_data_i[31:0]};
        end
      end else begin
        wr_data_o <= {16'h0, tx_merged};
      end
    end
  end

  // one-cycle write strobes, RAM commits with the bus ack
  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      arp_we_o <= 1'b0;
      tx_we_o  <= 1'b0;
    end else begin
      arp_we_o <= wait_phase_i && req_i.region.arp;
      tx_we_o  <= wait_phase_i && req_i.region.txbuf;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/gbe_cpu_read_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module gbe_cpu_read_mux (
  input  wire                       cpu_clk,
  input  wire                       cpu_rst,
  input  gbe_cpu_pkg::gbe_cpu_req_t req_i,
  input  gbe_cpu_pkg::gbe_cpu_cfg_t cfg_i,
  input  wire [11:0]                tx_size_i,
  input  wire [12:0]                rx_size_i,
  input  wire                       rx_ack_i,
  input  wire [31:0]                phy_status_i,
  input  wire [47:0]                arp_rd_data_i,
  input  wire [31:0]                tx_rd_data_i,
  input  wire [31:0]                rx_rd_data_i,
  output logic [31:0]               wb_dat_o
);

  import gbe_cpu_pkg::*;

  gbe_cpu_region_t src_region;
  logic [3:0]      src_idx;
  logic            src_half;
  logic [31:0]     reg_image;

  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      src_region <= '0;
      src_idx    <= 4'd0;
      src_half   <= 1'b0;
    end else if (req_i.trans && !req_i.we) begin
      src_region <= req_i.region;
      src_idx    <= req_i.offset.reg_view.idx;
      src_half   <= req_i.offset.arp_view.half;
    end
  end

  always_comb begin
    case (src_idx)
      REG_MAC_HI:      reg_image = {16'h0, cfg_i.mac[47:32]};
      REG_MAC_LO:      reg_image = cfg_i.mac[31:0];
      REG_GATEWAY:     reg_image = {24'h0, cfg_i.gateway};
      REG_IPADDR:      reg_image = cfg_i.ip;
      // receive size hidden while a new packet is being handed over
      REG_BUF_SIZES:   reg_image = {4'h0, tx_size_i, 3'h0, rx_ack_i ? 13'h0 : rx_size_i};
      REG_PORTS:       reg_image = {7'h0, cfg_i.promisc, 7'h0, cfg_i.enable, cfg_i.port};
      REG_CAPS:        reg_image = {7'h0, CAP_TX, 7'h0, CAP_RX, 16'h0};
      REG_PHY_STATUS:  reg_image = phy_status_i;
      REG_PHY_CONTROL: reg_image = cfg_i.phy_control;
      default:         reg_image = 32'h0;
    endcase
  end

  always_comb begin
    if (src_region.arp) begin
      wb_dat_o = src_half ? arp_rd_data_i[31:0] : {16'h0, arp_rd_data_i[47:32]};
    end else if (src_region.txbuf) begin
      wb_dat_o = tx_rd_data_i;
    end else if (src_region.rxbuf) begin
      wb_dat_o = rx_rd_data_i;
    end else if (src_region.regs) begin
      wb_dat_o = reg_image;
    end else begin
      wb_dat_o = 32'h0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/gbe_cpu_attach.sv ====
`timescale 1ns/1ps
`default_nettype none

module gbe_cpu_attach (
  input  wire                       cpu_clk,
  input  wire                       cpu_rst,
  input  wire                       wb_cyc_i,
  input  wire                       wb_stb_i,
  input  wire                       wb_we_i,
  input  wire [13:0]                wb_adr_i,
  input  wire [3:0]                 wb_sel_i,
  input  wire [31:0]                wb_dat_i,
  output logic [31:0]               wb_dat_o,
  output logic                      wb_ack_o,
  output gbe_cpu_pkg::gbe_cpu_cfg_t cfg_o,
  input  wire [7:0]                 arp_lookup_addr_i,
  output logic [47:0]               arp_lookup_data_o,
  input  wire [8:0]                 tx_pkt_addr_i,
  output logic [31:0]               tx_pkt_data_o,
  output logic [11:0]               tx_size_o,
  output logic                      tx_ready_o,
  input  wire                       tx_done_i,
  output logic [8:0]                rx_buf_addr_o,
  input  wire [31:0]                rx_buf_data_i,
  input  wire [11:0]                rx_size_i,
  input  wire                       rx_ready_i,
  output logic                      rx_ack_o,
  input  wire [31:0]                phy_status_i
);

  import gbe_cpu_pkg::*;

  gbe_cpu_req_t           req;
  logic                   wait_phase;
  logic [12:0]            rx_size;
  logic [47:0]            wr_data;
  logic                   arp_we;
  logic                   tx_we;
  logic [ARP_WIDTH-1:0]   arp_rd_data;
  logic [TXBUF_WIDTH-1:0] tx_rd_data;

  // receive buffer lives in the packet engine
  assign rx_buf_addr_o = req.offset.buf_view.word;

  gbe_cpu_bus_decode u_bus_decode (
    .cpu_clk      (cpu_clk),
    .cpu_rst      (cpu_rst),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_sel_i     (wb_sel_i),
    .wb_dat_i     (wb_dat_i),
    .req_o        (req),
    .wait_phase_o (wait_phase),
    .wb_ack_o     (wb_ack_o)
  );

  gbe_cpu_regs u_regs (
    .cpu_clk    (cpu_clk),
    .cpu_rst    (cpu_rst),
    .req_i      (req),
    .rx_ready_i (rx_ready_i),
    .rx_size_i  (rx_size_i),
    .tx_done_i  (tx_done_i),
    .cfg_o      (cfg_o),
    .tx_size_o  (tx_size_o),
    .tx_ready_o (tx_ready_o),
    .rx_ack_o   (rx_ack_o),
    .rx_size_o  (rx_size)
  );

  gbe_cpu_mem_merge u_mem_merge (
    .cpu_clk       (cpu_clk),
    .cpu_rst       (cpu_rst),
    .req_i         (req),
    .wait_phase_i  (wait_phase),
    .arp_rd_data_i (arp_rd_data),
    .tx_rd_data_i  (tx_rd_data),
    .wr_data_o     (wr_data),
    .arp_we_o      (arp_we),
    .tx_we_o       (tx_we)
  );

  gbe_cpu_read_mux u_read_mux (
    .cpu_clk       (cpu_clk),
    .cpu_rst       (cpu_rst),
    .req_i         (req),
    .cfg_i         (cfg_o),
    .tx_size_i     (tx_size_o),
    .rx_size_i     (rx_size),
    .rx_ack_i      (rx_ack_o),
    .phy_status_i  (phy_status_i),
    .arp_rd_data_i (arp_rd_data),
    .tx_rd_data_i  (tx_rd_data),
    .rx_rd_data_i  (rx_buf_data_i),
    .wb_dat_o      (wb_dat_o)
  );

  gbe_cpu_dp_ram #(
    .DEPTH (ARP_DEPTH),
    .WIDTH (ARP_WIDTH)
  ) u_arp_ram (
    .cpu_clk   (cpu_clk),
    .a_addr_i  (req.offset.arp_view.entry),
    .a_we_i    (arp_we),
    .a_wdata_i (wr_data),
    .b_addr_i  (arp_lookup_addr_i),
    .a_rdata_o (arp_rd_data),
    .b_rdata_o (arp_lookup_data_o)
  );

  gbe_cpu_dp_ram #(
    .DEPTH (TXBUF_DEPTH),
    .WIDTH (TXBUF_WIDTH)
  ) u_tx_ram (
    .cpu_clk   (cpu_clk),
    .a_addr_i  (req.offset.buf_view.word),
    .a_we_i    (tx_we),
    .a_wdata_i (wr_data[TXBUF_WIDTH-1:0]),
    .b_addr_i  (tx_pkt_addr_i),
    .a_rdata_o (tx_rd_data),
    .b_rdata_o (tx_pkt_data_o)
  );

endmodule

`default_nettype wire

// ==== dv/gbe_cpu_attach_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module gbe_cpu_attach_assert (
  input wire                       cpu_clk,
  input wire                       cpu_rst,
  input gbe_cpu_pkg::gbe_cpu_req_t req_i,
  input wire                       wb_ack_i,
  input wire                       arp_we_i,
  input wire                       tx_we_i,
  input wire                       tx_done_i,
  input wire                       tx_ready_i
);

  import gbe_cpu_pkg::*;

  logic size_wr;

  // lane 2 of the size register arms the transmit side
  assign size_wr = req_i.trans && req_i.we && req_i.region.regs &&
                   (req_i.offset.reg_view.idx == REG_BUF_SIZES) && req_i.sel[2];

  ack_single: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    wb_ack_i |=> !wb_ack_i)
    else $error("bus ack held high for two cycles");

  ack_after_trans: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    req_i.trans |-> ##[1:2] wb_ack_i)
    else $error("no bus ack within two cycles of a transaction");

  we_exclusive: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    !(arp_we_i && tx_we_i))
    else $error("ARP and transmit write strobes high together");

  tx_done_clears: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    (tx_done_i && !size_wr) |=> !tx_ready_i)
    else $error("tx_ready_o still high after tx_done_i");

  // only a size write may raise ready again
  tx_ready_stays_low: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    (!tx_ready_i && !size_wr) |=> !tx_ready_i)
    else $error("tx_ready_o rose without a size write");

endmodule

`default_nettype wire

// ==== dv/gbe_cpu_attach_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gbe_cpu_attach_tb;

  import gbe_cpu_pkg::*;

  localparam int NUM_TESTS = 6;
  localparam int ACK_LIMIT = 8;

  logic         cpu_clk;
  logic         cpu_rst;
  logic         wb_cyc;
  logic         wb_stb;
  logic         wb_we;
  logic [13:0]  wb_adr;
  logic [3:0]   wb_sel;
  logic [31:0]  wb_dat_w;
  logic [31:0]  wb_dat_r;
  logic         wb_ack;
  gbe_cpu_cfg_t cfg;
  logic [7:0]   arp_lookup_addr;
  logic [47:0]  arp_lookup_data;
  logic [8:0]   tx_pkt_addr;
  logic [31:0]  tx_pkt_data;
  logic [11:0]  tx_size;
  logic         tx_ready;
  logic         tx_done;
  logic [8:0]   rx_buf_addr;
  logic [31:0]  rx_buf_data;
  logic [11:0]  rx_size;
  logic         rx_ready;
  logic         rx_ack;
  logic [31:0]  phy_status;

  // reference model state
  gbe_cpu_cfg_t exp_cfg;
  logic [47:0]  arp_model [ARP_DEPTH];
  logic [31:0]  tx_model [TXBUF_DEPTH];
  logic [31:0]  rx_mem [512];
  logic [11:0]  exp_tx_size;
  logic [12:0]  exp_rx_size;

  integer       seed;
  int           last_lat;
  logic [8:0]   last_rx_addr;
  int           rx_ack_rises = 0;

  initial cpu_clk = 1'b0;
  always #10 cpu_clk = ~cpu_clk;

  // receive buffer of the packet engine
  assign rx_buf_data = rx_mem[rx_buf_addr];

  always @(posedge rx_ack) rx_ack_rises++;

  gbe_cpu_attach u_dut (
    .cpu_clk           (cpu_clk),
    .cpu_rst           (cpu_rst),
    .wb_cyc_i          (wb_cyc),
    .wb_stb_i          (wb_stb),
    .wb_we_i           (wb_we),
    .wb_adr_i          (wb_adr),
    .wb_sel_i          (wb_sel),
    .wb_dat_i          (wb_dat_w),
    .wb_dat_o          (wb_dat_r),
    .wb_ack_o          (wb_ack),
    .cfg_o             (cfg),
    .arp_lookup_addr_i (arp_lookup_addr),
    .arp_lookup_data_o (arp_lookup_data),
    .tx_pkt_addr_i     (tx_pkt_addr),
    .tx_pkt_data_o     (tx_pkt_data),
    .tx_size_o         (tx_size),
    .tx_ready_o        (tx_ready),
    .tx_done_i         (tx_done),
    .rx_buf_addr_o     (rx_buf_addr),
    .rx_buf_data_i     (rx_buf_data),
    .rx_size_i         (rx_size),
    .rx_ready_i        (rx_ready),
    .rx_ack_o          (rx_ack),
    .phy_status_i      (phy_status)
  );

  bind gbe_cpu_attach gbe_cpu_attach_assert u_assert (
    .cpu_clk    (cpu_clk),
    .cpu_rst    (cpu_rst),
    .req_i      (req),
    .wb_ack_i   (wb_ack_o),
    .arp_we_i   (arp_we),
    .tx_we_i    (tx_we),
    .tx_done_i  (tx_done_i),
    .tx_ready_i (tx_ready_o)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [47:0] act, input logic [47:0] exp);
    assert (act === exp) else begin
      $display("FAIL at %0t ns: %s expected %h actual %h", $time, name, exp, act);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic [13:0] reg_addr(input logic [3:0] idx);
    return REGS_BASE + {idx, 2'b00};
  endfunction

  task automatic model_reg_write(input logic [3:0] idx, input logic [3:0] sel,
                                 input logic [31:0] dat);
    logic [31:0] t;
    case (idx)
      REG_MAC_HI: begin
        t = merge_lanes({16'h0, exp_cfg.mac[47:32]}, dat, {2'b00, sel[1:0]});
        exp_cfg.mac[47:32] = t[15:0];
      end
      REG_MAC_LO: exp_cfg.mac[31:0] = merge_lanes(exp_cfg.mac[31:0], dat, sel);
      REG_GATEWAY: begin
        t = merge_lanes({24'h0, exp_cfg.gateway}, dat, {3'b000, sel[0]});
        exp_cfg.gateway = t[7:0];
      end
      REG_IPADDR: exp_cfg.ip = merge_lanes(exp_cfg.ip, dat, sel);
      REG_PORTS: begin
        t = merge_lanes({7'h0, exp_cfg.promisc, 7'h0, exp_cfg.enable, exp_cfg.port}, dat, sel);
        exp_cfg.port = t[15:0];
        exp_cfg.enable = t[16];
        exp_cfg.promisc = t[24];
      end
      REG_PHY_CONTROL: exp_cfg.phy_control = merge_lanes(exp_cfg.phy_control, dat, sel);
      default: begin
      end
    endcase
  endtask

  function automatic logic [31:0] reg_image(input logic [3:0] idx);
    logic [31:0] img;
    img = 32'h0;
    case (idx)
      REG_MAC_HI: img[15:0] = exp_cfg.mac[47:32];
      REG_MAC_LO: img = exp_cfg.mac[31:0];
      REG_GATEWAY: img[7:0] = exp_cfg.gateway;
      REG_IPADDR: img = exp_cfg.ip;
      REG_BUF_SIZES: begin
        img[27:16] = exp_tx_size;
        img[12:0] = exp_rx_size;
      end
      REG_PORTS: begin
        img[15:0] = exp_cfg.port;
        img[16] = exp_cfg.enable;
        img[24] = exp_cfg.promisc;
      end
      REG_CAPS: begin
        img[24] = CAP_TX;
        img[16] = CAP_RX;
      end
      REG_PHY_STATUS: img = phy_status;
      REG_PHY_CONTROL: img = exp_cfg.phy_control;
      default: img = 32'h0;
    endcase
    return img;
  endfunction

  task automatic check_cfg();
    check_eq("cfg_o.mac", cfg.mac, exp_cfg.mac);
    check_eq("cfg_o.ip", cfg.ip, exp_cfg.ip);
    check_eq("cfg_o.gateway", cfg.gateway, exp_cfg.gateway);
    check_eq("cfg_o.port", cfg.port, exp_cfg.port);
    check_eq("cfg_o.enable", cfg.enable, exp_cfg.enable);
    check_eq("cfg_o.promisc", cfg.promisc, exp_cfg.promisc);
    check_eq("cfg_o.phy_control", cfg.phy_control, exp_cfg.phy_control);
  endtask

  // request held until the edge that samples ack
  task automatic bus_access(input logic we, input logic [13:0] adr, input logic [3:0] sel,
                            input logic [31:0] dat, output logic [31:0] rdata);
    @(posedge cpu_clk);
    #2;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_sel = sel;
    wb_dat_w = dat;
    last_lat = 0;
    do begin
      @(posedge cpu_clk);
      #1;
      last_lat++;
    end while (!wb_ack && last_lat < ACK_LIMIT);
    if (!wb_ack) begin
      abort_run($sformatf("bus access to address %h was never acknowledged", adr));
    end
    rdata = wb_dat_r;
    last_rx_addr = rx_buf_addr;
    @(posedge cpu_clk);
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic wb_write(input logic [13:0] adr, input logic [3:0] sel, input logic [31:0] dat);
    logic [31:0] ignored;
    bus_access(1'b1, adr, sel, dat, ignored);
  endtask

  task automatic wb_read(input logic [13:0] adr, output logic [31:0] rdata);
    bus_access(1'b0, adr, 4'hF, 32'h0, rdata);
  endtask

  task automatic wait_rx_handshake(input int prev_rises);
    int cycles;
    cycles = 0;
    do begin
      @(posedge cpu_clk);
      #1;
      cycles++;
    end while (!(rx_ack_rises > prev_rises && !rx_ack) && cycles < 20);
    if (!(rx_ack_rises > prev_rises && !rx_ack)) begin
      abort_run("receive size handshake did not complete");
    end
  endtask

  task automatic test_reset_defaults();
    logic [31:0] rd;
    check_cfg();
    check_eq("tx_ready_o", tx_ready, 1'b0);
    check_eq("rx_ack_o", rx_ack, 1'b0);
    wb_read(reg_addr(REG_CAPS), rd);
    check_eq("wb_dat_o caps", rd, reg_image(REG_CAPS));
  endtask

  task automatic test_reg_lanes();
    logic [3:0]  regs_list [6];
    logic [31:0] dat;
    logic [31:0] rd;
    logic [3:0]  sel;
    regs_list = '{REG_MAC_HI, REG_MAC_LO, REG_GATEWAY, REG_IPADDR, REG_PORTS, REG_PHY_CONTROL};
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < 6; i++) begin
        dat = $random(seed);
        sel = $random(seed);
        model_reg_write(regs_list[i], sel, dat);
        wb_write(reg_addr(regs_list[i]), sel, dat);
        wb_read(reg_addr(regs_list[i]), rd);
        check_eq("wb_dat_o register", rd, reg_image(regs_list[i]));
      end
      check_cfg();
    end
    wb_read(reg_addr(REG_PHY_STATUS), rd);
    check_eq("wb_dat_o phy status", rd, reg_image(REG_PHY_STATUS));
  endtask

  task automatic test_arp();
    logic [7:0]  entry;
    logic [31:0] dat;
    logic [31:0] rd;
    logic [31:0] t;
    logic [3:0]  sel;
    logic [13:0] lo_adr;
    logic [13:0] hi_adr;
    for (int i = 0; i < 3; i++) begin
      entry = $random(seed);
      lo_adr = ARP_BASE + {entry, 1'b1, 2'b00};
      hi_adr = ARP_BASE + {entry, 1'b0, 2'b00};
      // start from a known entry before the partial writes
      dat = $random(seed);
      wb_write(lo_adr, 4'hF, dat);
      arp_model[entry][31:0] = dat;
      dat = $random(seed);
      wb_write(hi_adr, 4'h3, dat);
      arp_model[entry][47:32] = dat[15:0];
      dat = $random(seed);
      sel = $random(seed);
      wb_write(lo_adr, sel, dat);
      arp_model[entry][31:0] = merge_lanes(arp_model[entry][31:0], dat, sel);
      dat = $random(seed);
      sel = $random(seed);
      wb_write(hi_adr, sel, dat);
      t = merge_lanes({16'h0, arp_model[entry][47:32]}, dat, {2'b00, sel[1:0]});
      arp_model[entry][47:32] = t[15:0];
      wb_read(lo_adr, rd);
      check_eq("wb_dat_o arp low", rd, arp_model[entry][31:0]);
      wb_read(hi_adr, rd);
      check_eq("wb_dat_o arp high", rd, {16'h0, arp_model[entry][47:32]});
      @(posedge cpu_clk);
      #2;
      arp_lookup_addr = entry;
      @(posedge cpu_clk);
      #1;
      check_eq("arp_lookup_data_o", arp_lookup_data, arp_model[entry]);
    end
  endtask

  task automatic test_tx_path();
    logic [8:0]  word;
    logic [31:0] dat;
    logic [31:0] rd;
    logic [3:0]  sel;
    for (int i = 0; i < 3; i++) begin
      word = $random(seed);
      dat = $random(seed);
      wb_write(TXBUF_BASE + {word, 2'b00}, 4'hF, dat);
      tx_model[word] = dat;
      dat = $random(seed);
      sel = $random(seed);
      wb_write(TXBUF_BASE + {word, 2'b00}, sel, dat);
      tx_model[word] = merge_lanes(tx_model[word], dat, sel);
      wb_read(TXBUF_BASE + {word, 2'b00}, rd);
      check_eq("wb_dat_o tx buffer", rd, tx_model[word]);
      @(posedge cpu_clk);
      #2;
      tx_pkt_addr = word;
      @(posedge cpu_clk);
      #1;
      check_eq("tx_pkt_data_o", tx_pkt_data, tx_model[word]);
    end
    dat = $random(seed);
    wb_write(reg_addr(REG_BUF_SIZES), 4'b1100, dat);
    exp_tx_size = dat[27:16];
    check_eq("tx_ready_o", tx_ready, 1'b1);
    check_eq("tx_size_o", tx_size, exp_tx_size);
    wb_read(reg_addr(REG_BUF_SIZES), rd);
    check_eq("wb_dat_o buffer sizes", rd, reg_image(REG_BUF_SIZES));
    @(posedge cpu_clk);
    #2;
    tx_done = 1'b1;
    @(posedge cpu_clk);
    #2;
    tx_done = 1'b0;
    exp_tx_size = 12'd0;
    check_eq("tx_ready_o", tx_ready, 1'b0);
    check_eq("tx_size_o", tx_size, exp_tx_size);
  endtask

  task automatic test_rx_path();
    int          rises;
    logic [8:0]  word;
    logic [31:0] rd;
    rises = rx_ack_rises;
    @(posedge cpu_clk);
    #2;
    rx_size = $random(seed);
    rx_ready = 1'b1;
    wait_rx_handshake(rises);
    exp_rx_size = rx_size + 13'd1;
    wb_read(reg_addr(REG_BUF_SIZES), rd);
    check_eq("wb_dat_o buffer sizes", rd, reg_image(REG_BUF_SIZES));
    for (int i = 0; i < 3; i++) begin
      word = $random(seed);
      wb_read(RXBUF_BASE + {word, 2'b00}, rd);
      check_eq("wb_dat_o rx buffer", rd, rx_mem[word]);
      check_eq("rx_buf_addr_o", last_rx_addr, word);
    end
    // emptying the buffer lets the engine hand over the next packet
    rises = rx_ack_rises;
    rx_size = $random(seed);
    wb_write(reg_addr(REG_BUF_SIZES), 4'b0001, 32'h0);
    wait_rx_handshake(rises);
    exp_rx_size = rx_size + 13'd1;
    wb_read(reg_addr(REG_BUF_SIZES), rd);
    check_eq("wb_dat_o buffer sizes", rd, reg_image(REG_BUF_SIZES));
    rx_ready = 1'b0;
  endtask

  task automatic test_bus_timing();
    logic [31:0] dat;
    logic [31:0] rd;
    logic [8:0]  word;
    wb_read(reg_addr(REG_CAPS), rd);
    check_eq("register read ack latency", last_lat, 1);
    dat = $random(seed);
    model_reg_write(REG_GATEWAY, 4'h1, dat);
    wb_write(reg_addr(REG_GATEWAY), 4'h1, dat);
    check_eq("register write ack latency", last_lat, 1);
    check_eq("cfg_o.gateway", cfg.gateway, exp_cfg.gateway);
    word = $random(seed);
    dat = $random(seed);
    wb_write(TXBUF_BASE + {word, 2'b00}, 4'hF, dat);
    tx_model[word] = dat;
    check_eq("memory write ack latency", last_lat, 2);
    wb_read(TXBUF_BASE + {word, 2'b00}, rd);
    check_eq("wb_dat_o tx buffer", rd, tx_model[word]);
    wb_read(reg_addr(4'd5), rd);
    check_eq("wb_dat_o unused register", rd, 32'h0);
    wb_read(14'h0800, rd);
    check_eq("wb_dat_o unmapped", rd, 32'h0);
    check_eq("unmapped read ack latency", last_lat, 1);
  endtask

  initial begin
    #(NUM_TESTS * 2000);
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    seed = 32'h63684623;
    cpu_rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 14'h0;
    wb_sel = 4'h0;
    wb_dat_w = 32'h0;
    arp_lookup_addr = 8'h0;
    tx_pkt_addr = 9'h0;
    tx_done = 1'b0;
    rx_size = 12'h0;
    rx_ready = 1'b0;
    phy_status = $random(seed);
    for (int i = 0; i < 512; i++) begin
      rx_mem[i] = 32'h9e37_79b9 * (i + 1);
    end
    exp_cfg.mac = RST_MAC;
    exp_cfg.ip = RST_IP;
    exp_cfg.gateway = RST_GATEWAY;
    exp_cfg.port = RST_PORT;
    exp_cfg.enable = RST_ENABLE;
    exp_cfg.promisc = RST_PROMISC;
    exp_cfg.phy_control = RST_PHY_CONTROL;
    exp_tx_size = 12'd0;
    exp_rx_size = 13'd0;
    repeat (4) @(posedge cpu_clk);
    #2;
    cpu_rst = 1'b0;
    test_reset_defaults();
    test_reg_lanes();
    test_arp();
    test_tx_path();
    test_rx_path();
    test_bus_timing();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/gbe_cpu_pkg.sv
hdl/gbe_cpu_dp_ram.sv
hdl/gbe_cpu_bus_decode.sv
hdl/gbe_cpu_regs.sv
hdl/gbe_cpu_mem_merge.sv
hdl/gbe_cpu_read_mux.sv
hdl/gbe_cpu_attach.sv
dv/gbe_cpu_attach_assert.sv
dv/gbe_cpu_attach_tb.sv

// ==== Bender.yml ====
package:
  name: gbe_cpu_attach

sources:
  - files:
      - hdl/gbe_cpu_pkg.sv
      - hdl/gbe_cpu_dp_ram.sv
      - hdl/gbe_cpu_bus_decode.sv
      - hdl/gbe_cpu_regs.sv
      - hdl/gbe_cpu_mem_merge.sv
      - hdl/gbe_cpu_read_mux.sv
      - hdl/gbe_cpu_attach.sv
  - target: test
    files:
      - dv/gbe_cpu_attach_assert.sv
      - dv/gbe_cpu_attach_tb.sv
